/* filelist.f */
hdl/rv32_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/instr_decoder.sv
hdl/fetch_unit.sv
hdl/exec_stage.sv
hdl/store_unit.sv
hdl/rv32_core.sv
verification/rv32_core_assert.sv
verification/rv32_core_tb.sv

/* hdl/alu.sv */
`timescale 1ns/10ps

module alu (
  input  rv32_pkg::alu_op_e         op_i,
  input  logic [rv32_pkg::XLEN-1:0] operand_a_i,
  input  logic [rv32_pkg::XLEN-1:0] operand_b_i,
  output logic [rv32_pkg::XLEN-1:0] result_o
);

  logic [4:0] shamt;      // low 5 bits of b
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b_i[4:0];
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  always_comb begin
    case (op_i)
      rv32_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
      rv32_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
      rv32_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      rv32_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      rv32_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      // compares give 0 or 1
      rv32_pkg::ALU_SLT:  result_o = {{(rv32_pkg::XLEN-1){1'b0}}, lt_signed};
      rv32_pkg::ALU_SLTU: result_o = {{(rv32_pkg::XLEN-1){1'b0}}, lt_unsigned};
      rv32_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      rv32_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      rv32_pkg::ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt); // sign fill
      default:            result_o = operand_a_i + operand_b_i;
    endcase
  end

endmodule

/* hdl/exec_stage.sv */
`timescale 1ns/10ps

module exec_stage (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // from fetch
  input  logic                      fetch_valid_i,
  input  logic [rv32_pkg::XLEN-1:0] fetch_instr_i,
  output logic                      exec_ready_o,
  // to store unit
  output logic                      st_valid_o,
  output logic [rv32_pkg::XLEN-1:0] st_addr_o,
  output logic [rv32_pkg::XLEN-1:0] st_data_o,
  input  logic                      st_ready_i
);

  rv32_pkg::instr_class_e          cls;
  rv32_pkg::alu_op_e               alu_op;
  logic [rv32_pkg::REG_ADDR_W-1:0] rs1, rs2, rd;
  logic [rv32_pkg::XLEN-1:0]       imm;
  logic [rv32_pkg::XLEN-1:0]       rs1_data, rs2_data;
  logic [rv32_pkg::XLEN-1:0]       operand_b;
  logic [rv32_pkg::XLEN-1:0]       alu_result;
  logic [rv32_pkg::XLEN-1:0]       wdata;
  logic                            is_store;
  logic                            writes_rd;
  logic                            fire;

  instr_decoder instr_decoder_i (
    .instr_i  ( fetch_instr_i ),
    .class_o  ( cls           ),
    .alu_op_o ( alu_op        ),
    .rs1_o    ( rs1           ),
    .rs2_o    ( rs2           ),
    .rd_o     ( rd            ),
    .imm_o    ( imm           )
  );

  register_file register_file_i (
    .clk_i     ( clk_i    ),
    .rst_i     ( rst_i    ),
    .raddr_a_i ( rs1      ),
    .raddr_b_i ( rs2      ),
    .rdata_a_o ( rs1_data ),
    .rdata_b_o ( rs2_data ),
    .waddr_i   ( rd       ),
    .wdata_i   ( wdata    ),
    .we_i      ( fire && writes_rd ) // written at the accepting edge
  );

  // reg-reg uses rs2, imm ops and store address use the immediate
  assign operand_b = (cls == rv32_pkg::CLS_ALU_REG) ? rs2_data : imm;

  alu alu_i (
    .op_i        ( alu_op     ),
    .operand_a_i ( rs1_data   ),
    .operand_b_i ( operand_b  ),
    .result_o    ( alu_result )
  );

  assign is_store  = (cls == rv32_pkg::CLS_STORE);
  assign writes_rd = (cls == rv32_pkg::CLS_ALU_REG) || (cls == rv32_pkg::CLS_ALU_IMM) ||
                     (cls == rv32_pkg::CLS_LUI);
  assign wdata     = (cls == rv32_pkg::CLS_LUI) ? imm : alu_result;

  // stall only on a store the store unit cannot take
  assign exec_ready_o = !(is_store && !st_ready_i);
  assign fire         = fetch_valid_i && exec_ready_o;

  assign st_valid_o = fetch_valid_i && is_store;
  assign st_addr_o  = alu_result;        // rs1 + S imm
  assign st_data_o  = rs2_data;

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit #(
  parameter logic [rv32_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // instruction port
  output logic                      instr_req_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  output logic [rv32_pkg::XLEN-1:0] instr_addr_o,
  input  logic [rv32_pkg::XLEN-1:0] instr_rdata_i,
  // towards exec_stage
  output logic                      fetch_valid_o,
  output logic [rv32_pkg::XLEN-1:0] fetch_instr_o,
  input  logic                      exec_ready_i
);

  logic                      run_q;         // low in the first cycle of reset release
  logic [rv32_pkg::XLEN-1:0] pc_q;
  logic                      pending_q;     // granted, waiting for rvalid
  logic                      slot_valid_q;
  logic [rv32_pkg::XLEN-1:0] slot_instr_q;
  logic                      slot_free;
  logic                      req_acc;
  logic                      rvalid_ok;

  // slot empty, or handed to exec this cycle
  assign slot_free    = !slot_valid_q || exec_ready_i;
  assign instr_req_o  = run_q && !pending_q && slot_free;
  assign instr_addr_o = pc_q;                     // stable until gnt
  assign req_acc      = instr_req_o && instr_gnt_i;
  assign rvalid_ok    = instr_rvalid_i && pending_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_q     <= 1'b0;
      pc_q      <= BOOT_ADDR;
      pending_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (req_acc) begin
        pc_q      <= pc_q + 32'd4;                // sequential only, no jumps
        pending_q <= 1'b1;
      end else if (rvalid_ok) begin
        pending_q <= 1'b0;
      end
    end
  end

  // one-entry slot, refilled only by the rvalid of our own request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      slot_valid_q <= 1'b0;
    end else if (rvalid_ok) begin
      slot_valid_q <= 1'b1;
    end else if (exec_ready_i) begin
      slot_valid_q <= 1'b0;                       // consumed
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvalid_ok) begin
      slot_instr_q <= instr_rdata_i;
    end
  end

  assign fetch_valid_o = slot_valid_q;
  // empty slot shows a nop so decode never sees stale bits
  assign fetch_instr_o = slot_valid_q ? slot_instr_q : rv32_pkg::NOP_INSTR;

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
  input  logic [rv32_pkg::XLEN-1:0]       instr_i,
  output rv32_pkg::instr_class_e          class_o,
  output rv32_pkg::alu_op_e               alu_op_o,
  output logic [rv32_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv32_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [rv32_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [rv32_pkg::XLEN-1:0]       imm_o
);

  logic [rv32_pkg::OPC_W-1:0] opcode;
  logic [rv32_pkg::F3_W-1:0]  f3;
  logic [rv32_pkg::F7_W-1:0]  f7;
  logic [rv32_pkg::XLEN-1:0]  imm_i_type;
  logic [rv32_pkg::XLEN-1:0]  imm_s_type;
  logic [rv32_pkg::XLEN-1:0]  imm_u_type;
  logic                       f7_zero;
  logic                       f7_alt;     // the sub/sra pattern

  assign opcode = instr_i[rv32_pkg::OPC_LSB +: rv32_pkg::OPC_W];
  assign f3     = instr_i[rv32_pkg::F3_LSB +: rv32_pkg::F3_W];
  assign f7     = instr_i[rv32_pkg::F7_LSB +: rv32_pkg::F7_W];
  assign rd_o   = instr_i[rv32_pkg::RD_LSB +: rv32_pkg::REG_ADDR_W];
  assign rs1_o  = instr_i[rv32_pkg::RS1_LSB +: rv32_pkg::REG_ADDR_W];
  assign rs2_o  = instr_i[rv32_pkg::RS2_LSB +: rv32_pkg::REG_ADDR_W];

  assign f7_zero = (f7 == 7'b0000000);
  assign f7_alt  = (f7 == 7'b0100000);

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // funct3 to alu op, alt picks sub or sra
  function automatic rv32_pkg::alu_op_e alu_op_f(input logic [2:0] fn3, input logic alt);
    rv32_pkg::alu_op_e op;
    case (fn3)
      3'b000:  op = alt ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
      3'b001:  op = rv32_pkg::ALU_SLL;
      3'b010:  op = rv32_pkg::ALU_SLT;
      3'b011:  op = rv32_pkg::ALU_SLTU;
      3'b100:  op = rv32_pkg::ALU_XOR;
      3'b101:  op = alt ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
      3'b110:  op = rv32_pkg::ALU_OR;
      default: op = rv32_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    class_o  = rv32_pkg::CLS_NOP;   // anything unknown
    alu_op_o = rv32_pkg::ALU_ADD;   // store address uses add too
    imm_o    = '0;
    case (opcode)
      rv32_pkg::OPC_OP: begin
        if (f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101))) begin
          class_o  = rv32_pkg::CLS_ALU_REG;
          alu_op_o = alu_op_f(f3, f7_alt);
        end
      end
      rv32_pkg::OPC_OP_IMM: begin
        imm_o = imm_i_type;
        // shift immediates carry a funct7 of their own
        if (!((f3 == 3'b001 && !f7_zero) || (f3 == 3'b101 && !f7_zero && !f7_alt))) begin
          class_o  = rv32_pkg::CLS_ALU_IMM;
          alu_op_o = alu_op_f(f3, (f3 == 3'b101) && f7_alt);
        end
      end
      rv32_pkg::OPC_LUI: begin
        class_o = rv32_pkg::CLS_LUI;
        imm_o   = imm_u_type;
      end
      rv32_pkg::OPC_STORE: begin
        imm_o = imm_s_type;
        if (f3 == 3'b010) begin             // sw only
          class_o = rv32_pkg::CLS_STORE;
        end
      end
      default: ;
    endcase
  end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/10ps

module register_file (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [rv32_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv32_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv32_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv32_pkg::XLEN-1:0]       rdata_b_o,
  input  logic [rv32_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv32_pkg::XLEN-1:0]       wdata_i,
  input  logic                            we_i
);

  logic [rv32_pkg::XLEN-1:0] regs_q [1:31];  // no storage behind x0

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin  // x0 writes dropped
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // async read, write lands at the edge so next instr sees it
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* hdl/rv32_core.sv */
`timescale 1ns/10ps

module rv32_core #(
  parameter logic [rv32_pkg::XLEN-1:0] BOOT_ADDR = 32'h0000_0080
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // instruction port
  output logic                      instr_req_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  output logic [rv32_pkg::XLEN-1:0] instr_addr_o,
  input  logic [rv32_pkg::XLEN-1:0] instr_rdata_i,
  // data port
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  output logic [rv32_pkg::XLEN-1:0] data_addr_o,
  output logic [rv32_pkg::XLEN-1:0] data_wdata_o
);

  logic                      fetch_valid;
  logic [rv32_pkg::XLEN-1:0] fetch_instr;
  logic                      exec_ready;
  logic                      st_valid;
  logic [rv32_pkg::XLEN-1:0] st_addr;
  logic [rv32_pkg::XLEN-1:0] st_data;
  logic                      st_ready;

  ////////////////////////////////////////////////////////////
  // fetch
  ////////////////////////////////////////////////////////////
  fetch_unit #(
    .BOOT_ADDR ( BOOT_ADDR )
  ) fetch_unit_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fetch_valid_o  ( fetch_valid    ),
    .fetch_instr_o  ( fetch_instr    ),
    .exec_ready_i   ( exec_ready     )  // backpressure from stores
  );

  ////////////////////////////////////////////////////////////
  // decode, execute, writeback
  ////////////////////////////////////////////////////////////
  exec_stage exec_stage_i (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .fetch_valid_i ( fetch_valid ),
    .fetch_instr_i ( fetch_instr ),
    .exec_ready_o  ( exec_ready  ),
    .st_valid_o    ( st_valid    ),
    .st_addr_o     ( st_addr     ),
    .st_data_o     ( st_data     ),
    .st_ready_i    ( st_ready    )
  );

  ////////////////////////////////////////////////////////////
  // stores out to data memory
  ////////////////////////////////////////////////////////////
  store_unit store_unit_i (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .st_valid_i   ( st_valid     ),
    .st_addr_i    ( st_addr      ),
    .st_data_i    ( st_data      ),
    .st_ready_o   ( st_ready     ),
    .data_req_o   ( data_req_o   ),
    .data_gnt_i   ( data_gnt_i   ),
    .data_addr_o  ( data_addr_o  ),
    .data_wdata_o ( data_wdata_o )
  );

endmodule

/* hdl/rv32_pkg.sv */
package rv32_pkg;

  //////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////
  localparam int XLEN       = 32;  // data and address
  localparam int REG_ADDR_W = 5;   // x0..x31

  // addi x0,x0,0
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

  // instruction field positions
  localparam int OPC_LSB = 0;
  localparam int OPC_W   = 7;
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int F3_W    = 3;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F7_LSB  = 25;
  localparam int F7_W    = 7;

  //////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // reg-reg alu
    OPC_OP_IMM = 7'b0010011,  // reg-imm alu
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011   // only sw is kept
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  // what ID/EX does with the word
  typedef enum logic [2:0] {
    CLS_ALU_REG, CLS_ALU_IMM, CLS_LUI, CLS_STORE, CLS_NOP
  } instr_class_e;

endpackage

/* hdl/store_unit.sv */
`timescale 1ns/10ps

module store_unit (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // from exec stage
  input  logic                      st_valid_i,
  input  logic [rv32_pkg::XLEN-1:0] st_addr_i,
  input  logic [rv32_pkg::XLEN-1:0] st_data_i,
  output logic                      st_ready_o,
  // data port, word writes only
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  output logic [rv32_pkg::XLEN-1:0] data_addr_o,
  output logic [rv32_pkg::XLEN-1:0] data_wdata_o
);

  logic                      full_q;
  logic [rv32_pkg::XLEN-1:0] addr_q;
  logic [rv32_pkg::XLEN-1:0] data_q;
  logic                      accept;

  assign st_ready_o = !full_q || data_gnt_i;  // empty, or leaving this cycle
  assign accept     = st_valid_i && st_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;                         // also covers grant plus refill
    end else if (data_gnt_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= st_addr_i;
      data_q <= st_data_i;
    end
  end

  // held until granted
  assign data_req_o   = full_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = data_q;

endmodule

/* run.sh */
#!/bin/sh
# compile and run the rv32_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module rv32_core_tb -f filelist.f -o rv32_core_sim

./obj_dir/rv32_core_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"

/* verification/rv32_core_assert.sv */
`timescale 1ns/10ps

module rv32_core_assert (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic                      instr_req_i,
  input logic                      instr_gnt_i,
  input logic [rv32_pkg::XLEN-1:0] instr_addr_i,
  input logic                      data_req_i,
  input logic                      data_gnt_i,
  input logic [rv32_pkg::XLEN-1:0] data_addr_i,
  input logic [rv32_pkg::XLEN-1:0] data_wdata_i
);

  // quiet data port once reset has been seen at an edge
  data_idle_in_reset: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !data_req_i)
    else $error("data_req_o high during reset");

  data_held_until_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i) && $stable(data_wdata_i))
    else $error("data request dropped or changed before grant");

  instr_held_until_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("instruction request dropped or changed before grant");

  data_addr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_i |-> data_addr_i[1:0] == 2'b00)   // word stores only
    else $error("data_addr_o not word aligned");

endmodule

bind rv32_core rv32_core_assert rv32_core_assert_i (
  .clk_i        ( clk_i          ),
  .rst_i        ( rst_i          ),
  .instr_req_i  ( instr_req_o    ),
  .instr_gnt_i  ( instr_gnt_i    ),
  .instr_addr_i ( instr_addr_o   ),
  .data_req_i   ( data_req_o     ),
  .data_gnt_i   ( data_gnt_i     ),
  .data_addr_i  ( data_addr_o    ),
  .data_wdata_i ( data_wdata_o   )
);

/* verification/rv32_core_tb.sv */
`timescale 1ns/10ps

module rv32_core_tb;

  localparam logic [rv32_pkg::XLEN-1:0] IMEM_BASE = 32'h0000_1000;
  localparam int RAND_LEN       = 200;              // random part of the program
  localparam int PROG_LEN       = RAND_LEN + 32;    // then one sw per register
  localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 100;

  logic                      clk;
  logic                      rst;
  logic                      instr_req;
  logic                      instr_gnt;
  logic                      instr_rvalid;
  logic [rv32_pkg::XLEN-1:0] instr_addr;
  logic [rv32_pkg::XLEN-1:0] instr_rdata;
  logic                      data_req;
  logic                      data_gnt;
  logic [rv32_pkg::XLEN-1:0] data_addr;
  logic [rv32_pkg::XLEN-1:0] data_wdata;

  // program, one entry per instruction
  rv32_pkg::opcode_e               prog_kind [PROG_LEN];
  rv32_pkg::alu_op_e               prog_op   [PROG_LEN];
  logic [rv32_pkg::REG_ADDR_W-1:0] prog_rd   [PROG_LEN];
  logic [rv32_pkg::REG_ADDR_W-1:0] prog_rs1  [PROG_LEN];
  logic [rv32_pkg::REG_ADDR_W-1:0] prog_rs2  [PROG_LEN];
  logic [rv32_pkg::XLEN-1:0]       prog_imm  [PROG_LEN];
  logic [rv32_pkg::XLEN-1:0]       prog_mem  [PROG_LEN];  // encoded words

  logic [rv32_pkg::XLEN-1:0] exp_addr_q [$];
  logic [rv32_pkg::XLEN-1:0] exp_data_q [$];
  logic [rv32_pkg::XLEN-1:0] exp_pc;     // next fetch address
  int                        stores_total;
  int                        stores_seen;
  int                        cycle_cnt;
  logic                      done;

  rv32_core #(
    .BOOT_ADDR ( IMEM_BASE )
  ) rv32_core_i (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .instr_req_o    ( instr_req    ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_addr_o   ( instr_addr   ),
    .instr_rdata_i  ( instr_rdata  ),
    .data_req_o     ( data_req     ),
    .data_gnt_i     ( data_gnt     ),
    .data_addr_o    ( data_addr    ),
    .data_wdata_o   ( data_wdata   )
  );

  ////////////////////////////////////////////////////////////
  // error handling and compare tasks
  ////////////////////////////////////////////////////////////
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input logic [rv32_pkg::XLEN-1:0] got,
                            input logic [rv32_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input logic [rv32_pkg::XLEN-1:0] got,
                            input logic [rv32_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // program builder and reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [2:0] funct3_of(input rv32_pkg::alu_op_e op);
    case (op)
      rv32_pkg::ALU_ADD, rv32_pkg::ALU_SUB: return 3'b000;
      rv32_pkg::ALU_SLL:                    return 3'b001;
      rv32_pkg::ALU_SLT:                    return 3'b010;
      rv32_pkg::ALU_SLTU:                   return 3'b011;
      rv32_pkg::ALU_XOR:                    return 3'b100;
      rv32_pkg::ALU_SRL, rv32_pkg::ALU_SRA: return 3'b101;
      rv32_pkg::ALU_OR:                     return 3'b110;
      default:                              return 3'b111;  // and
    endcase
  endfunction

  function automatic logic [rv32_pkg::XLEN-1:0] encode(input int i);
    logic [2:0]                f3;
    logic [6:0]                f7;
    logic [6:0]                opc;
    logic [rv32_pkg::XLEN-1:0] word;
    f3  = funct3_of(prog_op[i]);
    f7  = (prog_op[i] == rv32_pkg::ALU_SUB || prog_op[i] == rv32_pkg::ALU_SRA) ?
          7'b0100000 : 7'b0000000;
    opc = prog_kind[i];
    case (prog_kind[i])
      rv32_pkg::OPC_OP:     word = {f7, prog_rs2[i], prog_rs1[i], f3, prog_rd[i], opc};
      rv32_pkg::OPC_OP_IMM: word = {prog_imm[i][11:0], prog_rs1[i], f3, prog_rd[i], opc};
      rv32_pkg::OPC_LUI:    word = {prog_imm[i][31:12], prog_rd[i], opc};
      default: begin        // sw, split S immediate
        word = {prog_imm[i][11:5], prog_rs2[i], prog_rs1[i], 3'b010, prog_imm[i][4:0], opc};
      end
    endcase
    return word;
  endfunction

  task automatic build_program();
    int   sel;
    int   simm;
    logic lui_base [32];                        // register last written by lui
    for (int r = 0; r < 32; r++) lui_base[r] = (r == 0);
    for (int i = 0; i < PROG_LEN; i++) begin
      prog_op[i]  = rv32_pkg::ALU_ADD;
      prog_rs1[i] = 5'($urandom_range(0, 31));
      prog_rs2[i] = 5'($urandom_range(0, 31));
      prog_rd[i]  = ($urandom_range(0, 15) == 0) ? 5'd0 : 5'($urandom_range(1, 31)); // x0 at times
      prog_imm[i] = '0;
      sel = (i < RAND_LEN) ? int'($urandom_range(0, 9)) : -1;
      if (sel < 0) begin                        // final dump, sw xr, 4*r(x0)
        prog_kind[i] = rv32_pkg::OPC_STORE;
        prog_rs1[i]  = 5'd0;
        prog_rs2[i]  = 5'(i - RAND_LEN);
        prog_imm[i]  = 32'(4 * (i - RAND_LEN));
      end else if (sel < 4) begin
        prog_kind[i] = rv32_pkg::OPC_OP;
        prog_op[i]   = rv32_pkg::alu_op_e'(4'($urandom_range(0, 9)));
      end else if (sel < 7) begin
        prog_kind[i] = rv32_pkg::OPC_OP_IMM;
        prog_op[i]   = rv32_pkg::alu_op_e'(4'($urandom_range(0, 9)));
        if (prog_op[i] == rv32_pkg::ALU_SUB) prog_op[i] = rv32_pkg::ALU_ADD; // no subi
        if (prog_op[i] == rv32_pkg::ALU_SLL || prog_op[i] == rv32_pkg::ALU_SRL) begin
          prog_imm[i] = 32'($urandom_range(0, 31));
        end else if (prog_op[i] == rv32_pkg::ALU_SRA) begin
          prog_imm[i] = 32'h400 | 32'($urandom_range(0, 31));  // srai marker in bit 10
        end else begin
          simm        = int'($urandom_range(0, 4095)) - 2048;
          prog_imm[i] = 32'(simm);
        end
      end else if (sel < 9) begin
        prog_kind[i] = rv32_pkg::OPC_LUI;
        prog_imm[i]  = $urandom() & 32'hffff_f000;
      end else begin                            // base x0 or a lui result, both signs
        prog_kind[i] = rv32_pkg::OPC_STORE;
        if (!lui_base[prog_rs1[i]]) prog_rs1[i] = 5'd0;
        simm         = 4 * int'($urandom_range(0, 1023)) - 2048;
        prog_imm[i]  = 32'(simm);
      end
      prog_mem[i] = encode(i);
      if (prog_kind[i] != rv32_pkg::OPC_STORE && prog_rd[i] != 5'd0) begin
        lui_base[prog_rd[i]] = (prog_kind[i] == rv32_pkg::OPC_LUI);
      end
    end
  endtask

  // expected result of one ALU operation, from the RV32I rules
  function automatic logic [rv32_pkg::XLEN-1:0] alu_ref(input rv32_pkg::alu_op_e op,
      input logic [rv32_pkg::XLEN-1:0] a, input logic [rv32_pkg::XLEN-1:0] b);
    case (op)
      rv32_pkg::ALU_ADD:  return a + b;
      rv32_pkg::ALU_SUB:  return a - b;
      rv32_pkg::ALU_OR:   return a | b;
      rv32_pkg::ALU_XOR:  return a ^ b;
      rv32_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv32_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      rv32_pkg::ALU_SLL:  return a << b[4:0];
      rv32_pkg::ALU_SRL:  return a >> b[4:0];
      rv32_pkg::ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      default:            return a & b;
    endcase
  endfunction

  function automatic void run_reference();
    logic [rv32_pkg::XLEN-1:0] regs [32];
    logic [rv32_pkg::XLEN-1:0] res;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    for (int i = 0; i < PROG_LEN; i++) begin
      res = '0;
      case (prog_kind[i])
        rv32_pkg::OPC_OP:     res = alu_ref(prog_op[i], regs[prog_rs1[i]], regs[prog_rs2[i]]);
        rv32_pkg::OPC_OP_IMM: res = alu_ref(prog_op[i], regs[prog_rs1[i]], prog_imm[i]);
        rv32_pkg::OPC_LUI:    res = prog_imm[i];
        default: begin
          exp_addr_q.push_back(regs[prog_rs1[i]] + prog_imm[i]);
          exp_data_q.push_back(regs[prog_rs2[i]]);
        end
      endcase
      if (prog_kind[i] != rv32_pkg::OPC_STORE && prog_rd[i] != 5'd0) regs[prog_rd[i]] = res;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // memory models and store compare
  ////////////////////////////////////////////////////////////
  function automatic logic [rv32_pkg::XLEN-1:0] fetch_word(input logic [rv32_pkg::XLEN-1:0] a);
    int idx;
    idx = int'((a - IMEM_BASE) >> 2);
    if (a >= IMEM_BASE && idx < PROG_LEN) return prog_mem[idx];
    return rv32_pkg::NOP_INSTR;                 // past the program
  endfunction

  task automatic serve_instr_port();
    logic [rv32_pkg::XLEN-1:0] addr;
    int                        stall;
    int                        lat;
    forever begin
      @(posedge clk);
      #2;
      instr_rvalid = 1'b0;
      @(negedge clk);                           // req settled, data_gnt already driven
      if (instr_req) begin
        stall = int'($urandom_range(0, 2));
        repeat (stall + 1) begin
          @(posedge clk);
          #2;
        end
        addr = instr_addr;
        check_addr("instr_addr_o", addr, exp_pc);
        exp_pc    = exp_pc + 32'd4;
        instr_gnt = 1'b1;
        @(posedge clk);                         // accepted here
        #2;
        instr_gnt = 1'b0;
        lat = int'($urandom_range(1, 3));
        repeat (lat - 1) begin
          @(posedge clk);
          #2;
        end
        instr_rdata  = fetch_word(addr);
        instr_rvalid = 1'b1;
      end
    end
  endtask

  task automatic serve_data_port();
    int stall;
    forever begin
      @(posedge clk);
      #2;
      data_gnt = 1'b0;
      if (data_req) begin
        stall = int'($urandom_range(0, 3));
        repeat (stall) begin
          @(posedge clk);
          #2;
        end
        data_gnt = 1'b1;
      end
    end
  endtask

  task automatic compare_stores();
    logic [rv32_pkg::XLEN-1:0] exp_a;
    logic [rv32_pkg::XLEN-1:0] exp_d;
    forever begin
      @(negedge clk);                           // mid cycle, all settled
      if (!rst && data_req && data_gnt) begin
        if (exp_addr_q.size() == 0) begin
          report_failure("the core issued a store that the reference does not expect");
        end else begin
          exp_a = exp_addr_q.pop_front();
          exp_d = exp_data_q.pop_front();
          check_addr("data_addr_o", data_addr, exp_a);
          check_data("data_wdata_o", data_wdata, exp_d);
          stores_seen++;
          if (stores_seen == stores_total) done = 1'b1;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // clock, watchdog, main sequence
  ////////////////////////////////////////////////////////////
  initial begin : clock_gen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
        report_failure("timeout, the final store did not arrive within the cycle limit");
      end
    end
  end

  initial begin : main
    rst          = 1'b1;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    data_gnt     = 1'b0;
    done         = 1'b0;
    stores_seen  = 0;
    exp_pc       = IMEM_BASE;
    void'($urandom(32'hbd56c456));
    build_program();
    run_reference();
    stores_total = exp_addr_q.size();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    fork
      serve_instr_port();
      serve_data_port();
      compare_stores();
    join_none
    wait (done);
    repeat (20) @(posedge clk);                 // room for a stray store to show up
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
